//--- src/asa_params.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and FIFO depths for the admission stage.
// copy index must be wide enough to index every vector bit.
// FIFO depths must be at least 3 so the almost-full margin exists.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`ifndef ASA_PARAMS_SVH
`define ASA_PARAMS_SVH

`define ASA_RCI_NBITS      6   // 64 table entries.
`define ASA_SCI_VEC_NBITS  8
`define ASA_QID_NBITS      8
`define ASA_BUF_PTR_NBITS  10
`define ASA_LEN_NBITS      12
`define ASA_PKT_ID_NBITS   8
`define ASA_COPY_NBITS     3   // log2 of vector width.
`define ASA_PIO_NBITS      16

`define ASA_PROC_DEPTH     4
`define ASA_ENQ_DEPTH      4

`endif

`default_nettype wire

//--- src/asa_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared descriptor and table entry types.
// asa_sci_entry_t doubles as the PIO data word.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "asa_params.svh"
`default_nettype none

package asa_pkg;

    typedef struct packed {
        logic [`ASA_SCI_VEC_NBITS-1:0] sci_vec;   // destination bits.
        logic [`ASA_QID_NBITS-1:0]     base_qid;
    } asa_sci_entry_t;

    typedef struct packed {
        logic [`ASA_RCI_NBITS-1:0]     rci;
        logic [`ASA_BUF_PTR_NBITS-1:0] buf_ptr;
        logic [`ASA_LEN_NBITS-1:0]     len;
        logic                          discard;
    } asa_pkt_t;

    typedef struct packed {
        logic [`ASA_BUF_PTR_NBITS-1:0] buf_ptr;
        logic [`ASA_LEN_NBITS-1:0]     len;
        asa_sci_entry_t                entry;
    } asa_proc_t;

    typedef struct packed {
        logic [`ASA_QID_NBITS-1:0]     qid;
        logic [`ASA_BUF_PTR_NBITS-1:0] buf_ptr;
        logic [`ASA_LEN_NBITS-1:0]     len;
        logic [`ASA_PKT_ID_NBITS-1:0]  packet_id;
        logic [`ASA_COPY_NBITS-1:0]    copy_idx;
        logic                          last;      // final copy.
        logic                          ucast;     // single bit vector.
    } asa_enq_t;

    typedef struct packed {
        logic [`ASA_BUF_PTR_NBITS-1:0] buf_ptr;
        logic [`ASA_LEN_NBITS-1:0]     len;
    } asa_discard_t;

endpackage

`default_nettype wire

//--- src/asa_fifo.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// synchronous FIFO, show-ahead output.
// push when full and pop when empty are ignored.
// afull needs DEPTH of 3 or more.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module asa_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic arst_n,
    input  logic push,
    input  T     din,
    input  logic pop,
    output T     dout,
    output logic empty,
    output logic full,
    output logic afull
);

    localparam int PTR_NBITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_NBITS = $clog2(DEPTH + 1);

    T                     mem [DEPTH];
    logic [PTR_NBITS-1:0] wr_ptr;
    logic [PTR_NBITS-1:0] rd_ptr;
    logic [CNT_NBITS-1:0] count;
    logic                 do_push;
    logic                 do_pop;

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_NBITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_NBITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither.
            endcase
        end
    end

    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == CNT_NBITS'(DEPTH));
    assign afull = (count >= CNT_NBITS'(DEPTH - 2));  // two slots or fewer left.

endmodule

`default_nettype wire

//--- src/asa_sci_table.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RCI to SCI table, one write and two registered reads.
// a lookup colliding with a write returns the old entry.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "asa_params.svh"
`default_nettype none

module asa_sci_table
    import asa_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      pio_wr,
    input  logic                      pio_rd,
    input  logic [`ASA_RCI_NBITS-1:0] pio_addr,
    input  asa_sci_entry_t            pio_wdata,
    output logic                      pio_rvalid,
    output asa_sci_entry_t            pio_rdata,
    input  logic [`ASA_RCI_NBITS-1:0] lkup_addr,
    output asa_sci_entry_t            lkup_data
);

    asa_sci_entry_t mem [1 << `ASA_RCI_NBITS];

    always_ff @(posedge clk) begin
        if (pio_wr) begin
            mem[pio_addr] <= pio_wdata;
        end
        lkup_data <= mem[lkup_addr];  // read every cycle.
        if (pio_rd) begin
            pio_rdata <= mem[pio_addr];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pio_rvalid <= 1'b0;
        end else begin
            pio_rvalid <= pio_rd;
        end
    end

endmodule

`default_nettype wire

//--- src/asa_front_end.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two stage descriptor admission.
// disc_valid or proc_push lands 2 cycles after pkt_valid.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "asa_params.svh"
`default_nettype none

module asa_front_end
    import asa_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      pkt_valid,
    input  asa_pkt_t                  pkt_in,
    output logic [`ASA_RCI_NBITS-1:0] lkup_addr,
    input  asa_sci_entry_t            lkup_data,
    output logic                      proc_push,
    output asa_proc_t                 proc_out,
    output logic                      disc_valid,
    output asa_discard_t              disc_out
);

    logic     s1_valid;
    asa_pkt_t s1_pkt;
    logic     s1_drop;

    assign lkup_addr = pkt_in.rci;

    // descriptor rides alongside the RAM read.
    always_ff @(posedge clk) begin
        s1_pkt <= pkt_in;
    end

    assign s1_drop = s1_pkt.discard | (lkup_data.sci_vec == '0);

    always_ff @(posedge clk) begin
        proc_out.buf_ptr <= s1_pkt.buf_ptr;
        proc_out.len     <= s1_pkt.len;
        proc_out.entry   <= lkup_data;
        disc_out.buf_ptr <= s1_pkt.buf_ptr;
        disc_out.len     <= s1_pkt.len;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid   <= 1'b0;
            proc_push  <= 1'b0;
            disc_valid <= 1'b0;
        end else begin
            s1_valid   <= pkt_valid;
            proc_push  <= s1_valid & ~s1_drop;
            disc_valid <= s1_valid & s1_drop;  // flagged or empty vector.
        end
    end

endmodule

`default_nettype wire

//--- src/asa_rep_fsm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// replication FSM, one enqueue per destination bit.
// bits go out lowest first. expects a non-zero vector.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "asa_params.svh"
`default_nettype none

module asa_rep_fsm
    import asa_pkg::*;
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         proc_empty,
    input  asa_proc_t                    proc_in,
    output logic                         proc_pop,
    input  logic                         enq_full,
    output logic                         enq_push,
    output asa_enq_t                     enq_out,
    output logic                         start,
    output logic                         copy,
    output logic                         done,
    input  logic [`ASA_PKT_ID_NBITS-1:0] packet_id,
    input  logic [`ASA_COPY_NBITS-1:0]   copy_idx
);

    typedef enum logic {IDLE, EMIT} state_t;

    state_t                         state;
    asa_proc_t                      pkt_q;
    logic [`ASA_SCI_VEC_NBITS-1:0]  rem_vec;
    logic                           ucast_q;
    logic [`ASA_COPY_NBITS-1:0]     bit_idx;
    logic                           last_bit;

    function automatic logic [`ASA_COPY_NBITS-1:0] low_idx(
        input logic [`ASA_SCI_VEC_NBITS-1:0] vec
    );
        logic [`ASA_COPY_NBITS-1:0] idx;
        idx = '0;
        for (int i = `ASA_SCI_VEC_NBITS - 1; i >= 0; i--) begin
            if (vec[i]) idx = `ASA_COPY_NBITS'(i);
        end
        return idx;
    endfunction

    assign bit_idx  = low_idx(rem_vec);
    assign last_bit = ((rem_vec & (rem_vec - 1'b1)) == '0);  // one bit left.

    assign proc_pop = (state == IDLE) & ~proc_empty;
    assign start    = proc_pop;
    assign enq_push = (state == EMIT) & ~enq_full;
    assign copy     = enq_push;
    assign done     = enq_push & last_bit;

    always_comb begin
        enq_out.qid       = pkt_q.entry.base_qid + `ASA_QID_NBITS'(bit_idx);
        enq_out.buf_ptr   = pkt_q.buf_ptr;
        enq_out.len       = pkt_q.len;
        enq_out.packet_id = packet_id;
        enq_out.copy_idx  = copy_idx;
        enq_out.last      = last_bit;
        enq_out.ucast     = ucast_q;
    end

    always_ff @(posedge clk) begin
        if (proc_pop) begin
            pkt_q   <= proc_in;
            rem_vec <= proc_in.entry.sci_vec;
            ucast_q <= $onehot(proc_in.entry.sci_vec);
        end else if (enq_push) begin
            rem_vec[bit_idx] <= 1'b0;  // retire sent bit.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else if (proc_pop) begin
            state <= EMIT;
        end else if (done) begin
            state <= IDLE;
        end
    end

endmodule

`default_nettype wire

//--- src/asa_rep_counter.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet id and copy index counters.
// packet id wraps, start wins over copy.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "asa_params.svh"
`default_nettype none

module asa_rep_counter (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         start,
    input  logic                         copy,
    input  logic                         done,
    output logic [`ASA_PKT_ID_NBITS-1:0] packet_id,
    output logic [`ASA_COPY_NBITS-1:0]   copy_idx
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            packet_id <= '0;
        end else if (done) begin
            packet_id <= packet_id + 1'b1;  // wraps at 256.
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            copy_idx <= '0;
        end else if (start) begin
            copy_idx <= '0;
        end else if (copy) begin
            copy_idx <= copy_idx + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/asa_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// admission and replication stage top.
// upstream must hold pkt_valid low while int_rep_bp is high.
// TM output is registered, one enqueue per cycle at most.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "asa_params.svh"
`default_nettype none

module asa_top
    import asa_pkg::*;
(
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      pio_wr,
    input  logic                      pio_rd,
    input  logic [`ASA_RCI_NBITS-1:0] pio_addr,
    input  asa_sci_entry_t            pio_wdata,
    output logic                      pio_rvalid,
    output asa_sci_entry_t            pio_rdata,
    input  logic                      pkt_valid,
    input  asa_pkt_t                  pkt_in,
    output logic                      int_rep_bp,
    output logic                      disc_valid,
    output asa_discard_t              disc_out,
    input  logic                      tm_bp,
    output logic                      asa_tm_enq_req,
    output asa_enq_t                  asa_tm_enq
);

    logic [`ASA_RCI_NBITS-1:0]    lkup_addr;
    asa_sci_entry_t               lkup_data;
    logic                         proc_push;
    asa_proc_t                    proc_din;
    logic                         proc_pop;
    asa_proc_t                    proc_dout;
    logic                         proc_empty;
    logic                         enq_push;
    asa_enq_t                     enq_din;
    logic                         enq_pop;
    asa_enq_t                     enq_dout;
    logic                         enq_empty;
    logic                         enq_full;
    logic                         rep_start;
    logic                         rep_copy;
    logic                         rep_done;
    logic [`ASA_PKT_ID_NBITS-1:0] packet_id;
    logic [`ASA_COPY_NBITS-1:0]   copy_idx;

    asa_sci_table u_sci_table (
        .clk(clk), .arst_n(arst_n),
        .pio_wr(pio_wr), .pio_rd(pio_rd), .pio_addr(pio_addr), .pio_wdata(pio_wdata),
        .pio_rvalid(pio_rvalid), .pio_rdata(pio_rdata),
        .lkup_addr(lkup_addr), .lkup_data(lkup_data)
    );

    asa_front_end u_front_end (
        .clk(clk), .arst_n(arst_n),
        .pkt_valid(pkt_valid), .pkt_in(pkt_in),
        .lkup_addr(lkup_addr), .lkup_data(lkup_data),
        .proc_push(proc_push), .proc_out(proc_din),
        .disc_valid(disc_valid), .disc_out(disc_out)
    );

    asa_fifo #(.T(asa_proc_t), .DEPTH(`ASA_PROC_DEPTH)) u_proc_fifo (
        .clk(clk), .arst_n(arst_n),
        .push(proc_push), .din(proc_din), .pop(proc_pop), .dout(proc_dout),
        .empty(proc_empty), .full(), .afull(int_rep_bp)
    );

    asa_rep_fsm u_rep_fsm (
        .clk(clk), .arst_n(arst_n),
        .proc_empty(proc_empty), .proc_in(proc_dout), .proc_pop(proc_pop),
        .enq_full(enq_full), .enq_push(enq_push), .enq_out(enq_din),
        .start(rep_start), .copy(rep_copy), .done(rep_done),
        .packet_id(packet_id), .copy_idx(copy_idx)
    );

    asa_rep_counter u_rep_counter (
        .clk(clk), .arst_n(arst_n),
        .start(rep_start), .copy(rep_copy), .done(rep_done),
        .packet_id(packet_id), .copy_idx(copy_idx)
    );

    asa_fifo #(.T(asa_enq_t), .DEPTH(`ASA_ENQ_DEPTH)) u_enq_fifo (
        .clk(clk), .arst_n(arst_n),
        .push(enq_push), .din(enq_din), .pop(enq_pop), .dout(enq_dout),
        .empty(enq_empty), .full(enq_full), .afull()
    );

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // TM enqueue port
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign enq_pop = ~enq_empty & ~tm_bp;  // held off by TM.

    always_ff @(posedge clk) begin
        if (enq_pop) begin
            asa_tm_enq <= enq_dout;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            asa_tm_enq_req <= 1'b0;
        end else begin
            asa_tm_enq_req <= enq_pop;
        end
    end

endmodule

`default_nettype wire

//--- tests/asa_tb_vectors.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stimulus table for asa_tb, included inside the module.
// read steps carry the entry expected back.
// packets only use entries written earlier in the table.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef ASA_TB_VECTORS_SVH
`define ASA_TB_VECTORS_SVH

typedef enum logic [1:0] {STEP_WR, STEP_RD, STEP_PKT} step_kind_t;

typedef struct packed {
    step_kind_t                kind;
    logic [`ASA_RCI_NBITS-1:0] addr;
    asa_sci_entry_t            entry;  // write data or expected read data.
    asa_pkt_t                  pkt;
} step_t;

step_t steps [MAX_STEPS];
int    num_steps = 0;

task automatic add_pio(
    input step_kind_t                    kind,
    input logic [`ASA_RCI_NBITS-1:0]     addr,
    input logic [`ASA_SCI_VEC_NBITS-1:0] vec,
    input logic [`ASA_QID_NBITS-1:0]     qid
);
    step_t s;
    s                = '0;
    s.kind           = kind;
    s.addr           = addr;
    s.entry.sci_vec  = vec;
    s.entry.base_qid = qid;
    steps[num_steps] = s;
    num_steps        = num_steps + 1;
endtask

task automatic add_pkt(
    input logic [`ASA_RCI_NBITS-1:0]     rci,
    input logic [`ASA_BUF_PTR_NBITS-1:0] buf_ptr,
    input logic [`ASA_LEN_NBITS-1:0]     len,
    input logic                          discard
);
    step_t s;
    s                = '0;
    s.kind           = STEP_PKT;
    s.pkt.rci        = rci;
    s.pkt.buf_ptr    = buf_ptr;
    s.pkt.len        = len;
    s.pkt.discard    = discard;
    steps[num_steps] = s;
    num_steps        = num_steps + 1;
endtask

task automatic load_vectors();
    // kind     rci     vec    base_qid
    add_pio(STEP_WR, 6'd0,  8'h01, 8'h10);
    add_pio(STEP_WR, 6'd5,  8'h04, 8'h10);
    add_pio(STEP_RD, 6'd5,  8'h04, 8'h10);
    add_pio(STEP_WR, 6'd9,  8'ha5, 8'h20);
    add_pio(STEP_RD, 6'd9,  8'ha5, 8'h20);
    add_pio(STEP_RD, 6'd0,  8'h01, 8'h10);
    add_pio(STEP_WR, 6'd12, 8'h00, 8'h30);  // empty vector.
    add_pio(STEP_WR, 6'd17, 8'hff, 8'hfc);  // qid wraps.
    add_pio(STEP_WR, 6'd33, 8'h80, 8'h40);
    add_pio(STEP_WR, 6'd40, 8'h18, 8'h00);
    add_pio(STEP_RD, 6'd17, 8'hff, 8'hfc);
    // rci   buf_ptr  len      discard
    add_pkt(6'd5,  10'h001, 12'h040, 1'b0);
    add_pkt(6'd9,  10'h002, 12'h100, 1'b0);
    add_pkt(6'd9,  10'h003, 12'h101, 1'b0);
    add_pkt(6'd5,  10'h004, 12'h020, 1'b1);
    add_pkt(6'd12, 10'h005, 12'h030, 1'b0);
    add_pkt(6'd33, 10'h006, 12'h7ff, 1'b0);
    // ~~~~ back to back burst ~~~~
    add_pkt(6'd17, 10'h010, 12'h200, 1'b0);
    add_pkt(6'd40, 10'h011, 12'h201, 1'b0);
    add_pkt(6'd0,  10'h012, 12'h202, 1'b0);
    add_pkt(6'd9,  10'h013, 12'h203, 1'b0);
    add_pkt(6'd12, 10'h014, 12'h204, 1'b0);
    add_pkt(6'd17, 10'h015, 12'h205, 1'b0);
    add_pkt(6'd5,  10'h016, 12'h206, 1'b0);
    add_pkt(6'd40, 10'h017, 12'h207, 1'b0);
    add_pkt(6'd17, 10'h018, 12'h208, 1'b0);
    add_pkt(6'd5,  10'h019, 12'h209, 1'b1);
    add_pkt(6'd9,  10'h01a, 12'h20a, 1'b0);
    add_pkt(6'd33, 10'h01b, 12'h20b, 1'b0);
    // table updates around lookups.
    add_pio(STEP_WR, 6'd40, 8'h03, 8'h50);
    add_pkt(6'd40, 10'h020, 12'h300, 1'b0);
    add_pkt(6'd40, 10'h021, 12'h301, 1'b0);
    add_pio(STEP_WR, 6'd40, 8'h06, 8'h60);
    add_pkt(6'd40, 10'h022, 12'h302, 1'b0);
    add_pio(STEP_RD, 6'd40, 8'h06, 8'h60);
endtask

`endif

//--- tests/asa_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table driven testbench for asa_top.
// expected traffic comes from a shadow table model.
// tm_bp is random throughout the run.
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`include "asa_params.svh"
`default_nettype none

module asa_tb
    import asa_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int MAX_STEPS  = 64;

    logic                         clk;
    logic                         arst_n;
    logic                         pio_wr;
    logic                         pio_rd;
    logic [`ASA_RCI_NBITS-1:0]    pio_addr;
    asa_sci_entry_t               pio_wdata;
    logic                         pio_rvalid;
    asa_sci_entry_t               pio_rdata;
    logic                         pkt_valid;
    asa_pkt_t                     pkt_in;
    logic                         int_rep_bp;
    logic                         disc_valid;
    asa_discard_t                 disc_out;
    logic                         tm_bp;
    logic                         asa_tm_enq_req;
    asa_enq_t                     asa_tm_enq;

    logic                         drop_mark;  // high with pkt_valid when a discard is due.
    logic [3:0]                   rep_hist;   // replicated sends, one bit per edge.
    logic [31:0]                  lcg_state;
    logic [`ASA_PKT_ID_NBITS-1:0] ref_pkt_id;
    logic                         rd_seen;
    logic                         bp_seen;
    logic [1:0]                   drop_pipe;
    logic [2:0]                   rep_pipe;   // replicated packets heading for the FIFO.
    int                           rep_pushed;
    int                           rep_retired;
    asa_enq_t                     exp_head;
    asa_sci_entry_t               shadow [1 << `ASA_RCI_NBITS];
    asa_enq_t                     exp_enq [$];
    asa_discard_t                 exp_disc [$];
    asa_sci_entry_t               exp_rd [$];
    int                           err_entry;
    int                           err_enq;
    int                           err_disc;
    int                           err_other;

    asa_top i_asa_top (
        .clk(clk), .arst_n(arst_n),
        .pio_wr(pio_wr), .pio_rd(pio_rd), .pio_addr(pio_addr), .pio_wdata(pio_wdata),
        .pio_rvalid(pio_rvalid), .pio_rdata(pio_rdata),
        .pkt_valid(pkt_valid), .pkt_in(pkt_in), .int_rep_bp(int_rep_bp),
        .disc_valid(disc_valid), .disc_out(disc_out),
        .tm_bp(tm_bp), .asa_tm_enq_req(asa_tm_enq_req), .asa_tm_enq(asa_tm_enq)
    );

    `include "asa_tb_vectors.svh"

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk) begin
        if (!arst_n) begin
            tm_bp <= 1'b0;
        end else begin
            lcg_state <= lcg_next(lcg_state);
            tm_bp     <= lcg_state[31];  // about half the cycles.
        end
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_entry(input string name, input asa_sci_entry_t got,
                               input asa_sci_entry_t exp);
        if (got !== exp) begin
            err_entry = err_entry + 1;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_enq(input string name, input asa_enq_t got, input asa_enq_t exp);
        if (got !== exp) begin
            err_enq = err_enq + 1;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_disc(input string name, input asa_discard_t got,
                              input asa_discard_t exp);
        if (got !== exp) begin
            err_disc = err_disc + 1;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string msg);
        err_other = err_other + 1;
        $display("Error at %0t: %s", $time, msg);
    endtask

    task automatic report_counts();
        $display("errors: entry %0d, enqueue %0d, discard %0d, other %0d",
                 err_entry, err_enq, err_disc, err_other);
    endtask

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output monitors, sampled mid cycle
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (arst_n) begin
            rep_pushed = rep_pushed + rep_pipe[2];
            if (pio_rvalid !== rd_seen)
                report_error("pio_rvalid did not follow pio_rd by one cycle");
            if (pio_rvalid === 1'b1) begin
                if (exp_rd.size() == 0) report_error("pio_rvalid with no read pending");
                else check_entry("pio_rdata", pio_rdata, exp_rd.pop_front());
            end
            if (disc_valid !== drop_pipe[1])
                report_error("disc_valid not 2 cycles after a discarded packet");
            if (disc_valid === 1'b1) begin
                if (exp_disc.size() == 0) report_error("discard report not expected");
                else check_disc("disc_out", disc_out, exp_disc.pop_front());
            end
            if (asa_tm_enq_req === 1'b1) begin
                if (bp_seen) report_error("enqueue issued after a cycle with tm_bp high");
                if (exp_enq.size() == 0) begin
                    report_error("enqueue not expected");
                end else begin
                    exp_head = exp_enq.pop_front();
                    if (exp_head.last) rep_retired = rep_retired + 1;
                    check_enq("asa_tm_enq", asa_tm_enq, exp_head);
                end
            end
            // FIFO holds no more than the packets pushed and not yet fully sent.
            if (int_rep_bp !== 1'b0 && rep_pushed - rep_retired < 2)
                report_error("int_rep_bp high with fewer than two packets queued");
        end
        rd_seen   = pio_rd;
        bp_seen   = tm_bp;
        drop_pipe = {drop_pipe[0], pkt_valid & drop_mark};
        rep_pipe  = {rep_pipe[1:0], pkt_valid & ~drop_mark};
    end

    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // driver and reference model
    //~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic next_cycle();
        @(posedge clk);
        rep_hist  = {rep_hist[2:0], 1'b0};
        pkt_valid <= 1'b0;
        drop_mark <= 1'b0;
        pio_wr    <= 1'b0;
        pio_rd    <= 1'b0;
    endtask

    task automatic send_packet(input asa_pkt_t pkt);
        asa_sci_entry_t ent;
        asa_enq_t       e;
        asa_discard_t   d;
        logic           drop;
        int             nbits;
        int             k;
        int             i;
        ent  = shadow[pkt.rci];
        drop = pkt.discard || (ent.sci_vec == '0);
        if (drop) begin
            d.buf_ptr = pkt.buf_ptr;
            d.len     = pkt.len;
            exp_disc.push_back(d);
        end else begin
            nbits = 0;
            for (i = 0; i < `ASA_SCI_VEC_NBITS; i++) nbits = nbits + ent.sci_vec[i];
            k = 0;
            for (i = 0; i < `ASA_SCI_VEC_NBITS; i++) begin
                if (ent.sci_vec[i]) begin
                    e.qid       = ent.base_qid + `ASA_QID_NBITS'(i);
                    e.buf_ptr   = pkt.buf_ptr;
                    e.len       = pkt.len;
                    e.packet_id = ref_pkt_id;
                    e.copy_idx  = `ASA_COPY_NBITS'(k);
                    e.last      = (k == nbits - 1);
                    e.ucast     = (nbits == 1);
                    exp_enq.push_back(e);
                    k = k + 1;
                end
            end
            ref_pkt_id  = ref_pkt_id + 1'b1;
            rep_hist[0] = 1'b1;
        end
        pkt_in    <= pkt;
        pkt_valid <= 1'b1;
        drop_mark <= drop;
    endtask

    initial begin
        int s;
        clk         = 1'b0;
        arst_n      = 1'b0;
        pio_wr      = 1'b0;
        pio_rd      = 1'b0;
        pio_addr    = '0;
        pio_wdata   = '0;
        pkt_valid   = 1'b0;
        pkt_in      = '0;
        tm_bp       = 1'b0;
        drop_mark   = 1'b0;
        rep_hist    = '0;
        lcg_state   = 32'hf18371c7;
        ref_pkt_id  = '0;
        rep_pushed  = 0;
        rep_retired = 0;
        err_entry   = 0;
        err_enq     = 0;
        err_disc    = 0;
        err_other   = 0;
        load_vectors();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        for (s = 0; s < num_steps; s++) begin
            next_cycle();
            case (steps[s].kind)
                STEP_WR: begin
                    pio_wr    <= 1'b1;
                    pio_addr  <= steps[s].addr;
                    pio_wdata <= steps[s].entry;
                    shadow[steps[s].addr] = steps[s].entry;
                end
                STEP_RD: begin
                    pio_rd   <= 1'b1;
                    pio_addr <= steps[s].addr;
                    exp_rd.push_back(steps[s].entry);
                end
                default: begin
                    // int_rep_bp seen here is a cycle old, a push lands 3 edges on.
                    while (int_rep_bp || rep_hist[3]) next_cycle();
                    send_packet(steps[s].pkt);
                end
            endcase
        end
        next_cycle();
        while (exp_enq.size() != 0 || exp_disc.size() != 0 || exp_rd.size() != 0)
            @(posedge clk);
        repeat (20) @(posedge clk);  // catch stray outputs.
        report_counts();
        if (err_entry + err_enq + err_disc + err_other == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (num_steps > 0);
        #(num_steps * 200 * CLK_PERIOD);
        $display("Error: watchdog expired before expected traffic drained");
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- asa_top.f
+incdir+src
+incdir+tests
src/asa_pkg.sv
src/asa_fifo.sv
src/asa_sci_table.sv
src/asa_front_end.sv
src/asa_rep_fsm.sv
src/asa_rep_counter.sv
src/asa_top.sv
tests/asa_tb.sv

//--- Bender.yml
package:
  name: asa

sources:
  - include_dirs:
      - src
    files:
      - src/asa_pkg.sv
      - src/asa_fifo.sv
      - src/asa_sci_table.sv
      - src/asa_front_end.sv
      - src/asa_rep_fsm.sv
      - src/asa_rep_counter.sv
      - src/asa_top.sv
  - target: test
    include_dirs:
      - src
      - tests
    files:
      - tests/asa_tb.sv
